/* hdl/tag_mem_pkg.sv */
// memory macro access types
package tag_mem_pkg;

    typedef logic [15:0] mem_word_t;
    typedef logic [5:0]  mem_addr_t;
    typedef logic [1:0]  mem_bank_t;

    // macro pin bundle, 27 bits
    typedef struct packed {
        mem_bank_t bank;
        mem_addr_t address;
        logic      pc_b;     // precharge, active low
        logic      se;       // sense enable
        logic      we;       // write enable
        mem_word_t wdata;
    } mem_pins_t;

    // one access request, 26 bits
    typedef struct packed {
        logic      valid;
        logic      write;
        mem_bank_t bank;
        mem_addr_t address;
        mem_word_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_bank_sel,
        seq_precharge,
        seq_address,
        seq_strobe,
        seq_data,
        seq_release
    } seq_state_t;

endpackage

/* hdl/sensor_pkg.sv */
// sensor sample and readout types
package sensor_pkg;

    localparam int num_sensors = 2;

    typedef enum logic {
        sensor_1 = 1'b0,
        sensor_2 = 1'b1
    } sensor_id_t;

    typedef struct packed {
        logic [7:0] timestamp; // upper byte of the stored word
        logic [7:0] adc;
    } sample_t;

    typedef logic [6:0] fill_t; // 0 to 64 words

    typedef enum logic [2:0] {
        rs_idle,
        rs_fetch,
        rs_wait_word,
        rs_drain,
        rs_done
    } rd_state_t;

    // macro bank 2 for sensor_1 and bank 3 for sensor_2
    function automatic logic [1:0] sensor_bank(sensor_id_t id);
        return (id == sensor_1) ? 2'd2 : 2'd3;
    endfunction

endpackage

/* hdl/bank_fill_regs.sv */
// sensor bank fill counters
`timescale 1ns/1ps

module bank_fill_regs
    import sensor_pkg::*;
#(
    parameter int bank_depth = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       inc,
    input  logic       dec,
    input  sensor_id_t inc_sensor,
    input  sensor_id_t dec_sensor,
    output fill_t      fill_1,
    output fill_t      fill_2
);

    fill_t fill_q [num_sensors];

    for (genvar i = 0; i < num_sensors; i++) begin : g_cnt
        logic up;
        logic dn;

        // saturate at both ends
        assign up = inc && (inc_sensor == sensor_id_t'(i)) && (fill_q[i] < fill_t'(bank_depth));
        assign dn = dec && (dec_sensor == sensor_id_t'(i)) && (fill_q[i] != '0);

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                fill_q[i] <= '0;
            end else begin
                fill_q[i] <= fill_q[i] + fill_t'(up) - fill_t'(dn);
            end
        end
    end

    assign fill_1 = fill_q[0];
    assign fill_2 = fill_q[1];

endmodule

/* hdl/mem_access_seq.sv */
// memory macro access sequencer
`timescale 1ns/1ps

module mem_access_seq
    import tag_mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  wr_req,
    input  mem_req_t  rd_req,
    input  mem_word_t mem_rdata,
    output logic      wr_done,
    output logic      rd_done,
    output mem_word_t rdata_q,
    output mem_pins_t mem_pins
);

    seq_state_t state;
    mem_req_t   cur;
    mem_req_t   next_req;

    assign next_req = wr_req.valid ? wr_req : rd_req; // write wins a tie

    assign wr_done = (state == seq_release) && cur.write;
    assign rd_done = (state == seq_release) && !cur.write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= seq_idle;
            mem_pins <= '{bank: '0, address: '0, pc_b: 1'b1, se: 1'b0, we: 1'b0, wdata: '0};
        end else begin
            case (state)
                seq_idle: begin
                    if (wr_req.valid || rd_req.valid) begin
                        mem_pins.bank <= next_req.bank;
                        state         <= seq_bank_sel;
                    end
                end
                seq_bank_sel: begin
                    mem_pins.pc_b <= 1'b0;
                    state         <= seq_precharge;
                end
                seq_precharge: begin
                    mem_pins.address <= cur.address;
                    mem_pins.wdata   <= cur.wdata;
                    state            <= seq_address;
                end
                seq_address: begin
                    mem_pins.se <= !cur.write;
                    mem_pins.we <= cur.write;
                    state       <= seq_strobe;
                end
                seq_strobe: begin
                    state <= seq_data; // macro output settles here
                end
                seq_data: begin
                    mem_pins.pc_b <= 1'b1;
                    mem_pins.se   <= 1'b0;
                    mem_pins.we   <= 1'b0;
                    state         <= seq_release;
                end
                seq_release: begin
                    state <= seq_idle;
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // granted request, held for the whole access
    always_ff @(posedge clk) begin
        if (state == seq_idle) begin
            cur <= next_req;
        end
    end

    // only reads touch rdata_q so a word survives interleaved writes
    always_ff @(posedge clk) begin
        if (state == seq_data && !cur.write) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

/* hdl/sample_capture.sv */
// sensor sample intake
`timescale 1ns/1ps

module sample_capture
    import tag_mem_pkg::*;
    import sensor_pkg::*;
#(
    parameter int bank_depth = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_req,
    input  sensor_id_t sample_sensor,
    input  sample_t    sample,
    input  fill_t      fill_1,
    input  fill_t      fill_2,
    input  logic       wr_done,
    output logic       sample_ack,
    output mem_req_t   wr_req,
    output logic       inc,
    output sensor_id_t inc_sensor
);

    sensor_id_t sensor_q;
    mem_word_t  wdata_q;
    logic       wr_valid;
    logic       req_new;
    fill_t      fill_in;
    fill_t      fill_cur;

    assign fill_in  = (sample_sensor == sensor_1) ? fill_1 : fill_2;
    assign fill_cur = (sensor_q == sensor_1) ? fill_1 : fill_2;
    assign req_new  = sample_req && !sample_ack && !wr_valid;

    // address follows the live count so a readout in between cannot leave a hole
    assign wr_req = '{
        valid:   wr_valid,
        write:   1'b1,
        bank:    sensor_bank(sensor_q),
        address: fill_cur[5:0],
        wdata:   wdata_q
    };

    assign inc        = wr_valid && wr_done;
    assign inc_sensor = sensor_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_ack <= 1'b0;
            wr_valid   <= 1'b0;
        end else if (req_new) begin
            if (fill_in >= fill_t'(bank_depth)) begin
                sample_ack <= 1'b1; // bank full, drop it
            end else begin
                wr_valid <= 1'b1;
            end
        end else if (inc) begin
            wr_valid   <= 1'b0;
            sample_ack <= 1'b1;
        end else if (sample_ack && !sample_req) begin
            sample_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) begin
            sensor_q <= sample_sensor;
            wdata_q  <= {sample.timestamp, sample.adc};
        end
    end

endmodule

/* hdl/readout_ctrl.sv */
// sensor bank readout control
`timescale 1ns/1ps

module readout_ctrl
    import tag_mem_pkg::*;
    import sensor_pkg::*;
#(
    parameter int bank_depth = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       read_req,
    input  sensor_id_t read_sensor,
    input  fill_t      fill_1,
    input  fill_t      fill_2,
    input  logic       rd_done,
    input  mem_word_t  rdata_q,
    input  logic       ser_ready,
    output logic       read_ack,
    output mem_req_t   rd_req,
    output logic       dec,
    output sensor_id_t dec_sensor,
    output logic       ser_load,
    output mem_word_t  ser_word
);

    rd_state_t  state;
    sensor_id_t sensor_q;
    logic       rd_valid;
    logic       have_word;
    fill_t      words_q;
    logic [3:0] drain_cnt;
    fill_t      fill_cur;
    fill_t      rd_ptr;

    assign fill_cur = (sensor_q == sensor_1) ? fill_1 : fill_2;
    assign rd_ptr   = fill_cur - fill_t'(1); // newest word first

    assign rd_req = '{
        valid:   rd_valid,
        write:   1'b0,
        bank:    sensor_bank(sensor_q),
        address: rd_ptr[5:0],
        wdata:   '0
    };

    assign dec        = rd_done;
    assign dec_sensor = sensor_q;
    assign ser_load   = (state == rs_wait_word) && have_word && ser_ready;
    assign ser_word   = rdata_q; // stable until our next read

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= rs_idle;
            sensor_q  <= sensor_1;
            rd_valid  <= 1'b0;
            have_word <= 1'b0;
            words_q   <= '0;
            drain_cnt <= '0;
            read_ack  <= 1'b0;
        end else begin
            case (state)
                rs_idle: begin
                    if (read_req && !read_ack) begin
                        sensor_q <= read_sensor;
                        words_q  <= '0;
                        state    <= rs_fetch;
                    end
                end
                rs_fetch: begin
                    // cap at one bank's worth even if samples keep arriving
                    if (fill_cur == '0 || words_q == fill_t'(bank_depth)) begin
                        drain_cnt <= '0;
                        state     <= rs_drain;
                    end else begin
                        rd_valid <= 1'b1;
                        state    <= rs_wait_word;
                    end
                end
                rs_wait_word: begin
                    if (rd_done) begin
                        rd_valid  <= 1'b0;
                        have_word <= 1'b1;
                    end
                    if (ser_load) begin
                        have_word <= 1'b0;
                        words_q   <= words_q + fill_t'(1);
                        state     <= rs_fetch;
                    end
                end
                rs_drain: begin
                    // holding register empty, so at most one word is left shifting
                    if (ser_ready) begin
                        drain_cnt <= drain_cnt + 4'd1;
                        if (drain_cnt == 4'd15) begin
                            read_ack <= 1'b1;
                            state    <= rs_done;
                        end
                    end
                end
                rs_done: begin
                    if (!read_req) begin
                        read_ack <= 1'b0;
                        state    <= rs_idle;
                    end
                end
                default: begin
                    state <= rs_idle;
                end
            endcase
        end
    end

endmodule

/* hdl/word_serializer.sv */
// word to bit serializer
`timescale 1ns/1ps

module word_serializer
    import tag_mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  mem_word_t word,
    output logic      ready,
    output logic      tx_bit,
    output logic      tx_valid,
    output logic      busy
);

    mem_word_t  shift_q;
    mem_word_t  hold_q;
    logic       hold_full;
    logic       active;
    logic [3:0] bit_cnt;
    logic       free;

    assign free     = !active || (bit_cnt == 4'd15); // shifter empty next cycle
    assign ready    = !hold_full;
    assign tx_bit   = shift_q[0]; // lsb first
    assign tx_valid = active;
    assign busy     = active || hold_full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            hold_full <= 1'b0;
            bit_cnt   <= '0;
        end else if (free) begin
            active    <= hold_full || load;
            hold_full <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            bit_cnt <= bit_cnt + 4'd1;
            if (load) begin
                hold_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (free) begin
            shift_q <= hold_full ? hold_q : word;
        end else begin
            shift_q <= shift_q >> 1;
            if (load) begin
                hold_q <= word;
            end
        end
    end

endmodule

/* hdl/sensor_tag_mem.sv */
// sensor tag memory top
`timescale 1ns/1ps

module sensor_tag_mem
    import tag_mem_pkg::*;
    import sensor_pkg::*;
#(
    parameter int bank_depth = 64
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_req,
    input  sensor_id_t sample_sensor,
    input  sample_t    sample,
    input  logic       read_req,
    input  sensor_id_t read_sensor,
    input  mem_word_t  mem_rdata,
    output logic       sample_ack,
    output logic       read_ack,
    output logic       tx_bit,
    output logic       tx_valid,
    output mem_pins_t  mem_pins
);

    mem_req_t   wr_req;
    mem_req_t   rd_req;
    logic       wr_done;
    logic       rd_done;
    mem_word_t  rdata_q;
    fill_t      fill_1;
    fill_t      fill_2;
    logic       inc;
    logic       dec;
    sensor_id_t inc_sensor;
    sensor_id_t dec_sensor;
    logic       ser_load;
    logic       ser_ready;
    mem_word_t  ser_word;

    bank_fill_regs #(.bank_depth(bank_depth)) u_fill (
        .clk, .reset, .inc, .dec, .inc_sensor, .dec_sensor, .fill_1, .fill_2
    );

    mem_access_seq u_seq (
        .clk, .reset, .wr_req, .rd_req, .mem_rdata, .wr_done, .rd_done, .rdata_q, .mem_pins
    );

    sample_capture #(.bank_depth(bank_depth)) u_capture (
        .clk, .reset, .sample_req, .sample_sensor, .sample, .fill_1, .fill_2,
        .wr_done, .sample_ack, .wr_req, .inc, .inc_sensor
    );

    readout_ctrl #(.bank_depth(bank_depth)) u_readout (
        .clk, .reset, .read_req, .read_sensor, .fill_1, .fill_2, .rd_done, .rdata_q,
        .ser_ready, .read_ack, .rd_req, .dec, .dec_sensor, .ser_load, .ser_word
    );

    word_serializer u_ser (
        .clk,
        .reset,
        .load     (ser_load),
        .word     (ser_word),
        .ready    (ser_ready),
        .tx_bit,
        .tx_valid,
        .busy     ()      // readout paces its drain off ready
    );

endmodule

/* include/tb_checks.svh */
// testbench models and checks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// macro model, read data registered so it is settled by the data state
task automatic run_mem_model();
    logic we_q;
    we_q = 1'b0;
    mem_rdata = '0;
    for (int a = 0; a < 256; a++) begin
        macro_mem[a] = {~a[7:0], a[7:0]}; // fill pattern over the full address
    end
    forever begin
        @(posedge clk);
        if (mem_pins.we === 1'b1) begin
            macro_mem[{mem_pins.bank, mem_pins.address}] = mem_pins.wdata;
            if (!we_q) begin
                wr_log.push_back(mem_pins); // one record per write strobe
            end
        end
        we_q = (mem_pins.we === 1'b1);
        mem_rdata <= (mem_pins.se === 1'b1) ? macro_mem[{mem_pins.bank, mem_pins.address}]
                                            : 16'h0000;
    end
endtask

// sensor_1 lives in bank 2, sensor_2 in bank 3
function automatic mem_bank_t exp_bank(sensor_id_t s);
    return (s == sensor_1) ? 2'd2 : 2'd3;
endfunction

// expected bit idx of a readout: newest word first, each lsb first
function automatic logic ref_readout(sensor_id_t s, int idx);
    int        slot;
    mem_word_t w;
    slot = int'(s);
    w = shadow[slot][shadow_n[slot] - 1 - idx / 16];
    return w[idx % 16];
endfunction

function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_word(string name, mem_word_t got, mem_word_t exp);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_addr(string name, mem_addr_t got, mem_addr_t exp);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_bank(string name, mem_bank_t got, mem_bank_t exp);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

`endif

/* verification/tb_sensor_tag_mem.sv */
// sensor tag memory testbench
`timescale 1ns/1ps

module tb_sensor_tag_mem
    import tag_mem_pkg::*;
    import sensor_pkg::*;
();

    localparam int bank_depth  = 64;
    localparam int ack_limit   = 100;
    localparam int read_limit  = 20000;

    logic       clk;
    logic       reset;
    logic       sample_req;
    sensor_id_t sample_sensor;
    sample_t    sample;
    logic       read_req;
    sensor_id_t read_sensor;
    mem_word_t  mem_rdata;
    logic       sample_ack;
    logic       read_ack;
    logic       tx_bit;
    logic       tx_valid;
    mem_pins_t  mem_pins;

    mem_word_t   macro_mem [256];
    mem_pins_t   wr_log [$];
    mem_word_t   shadow [num_sensors][bank_depth];
    int          shadow_n [num_sensors];
    int          mismatches = 0;
    int          other_errors = 0;
    int          bit_count = 0;
    int          rd_base;
    sensor_id_t  rd_sensor_exp;
    logic [31:0] lcg_state;
    logic        timed_out;

    `include "tb_checks.svh"

    sensor_tag_mem #(.bank_depth(bank_depth)) DUT (
        .clk, .reset, .sample_req, .sample_sensor, .sample, .read_req, .read_sensor,
        .mem_rdata, .sample_ack, .read_ack, .tx_bit, .tx_valid, .mem_pins
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial run_mem_model();

    // compares every serial bit against the reference
    always @(posedge clk) begin : scoreboard
        int idx;
        if (tx_valid) begin
            idx = bit_count - rd_base;
            if (idx < 16 * shadow_n[int'(rd_sensor_exp)]) begin
                check_bit("tx_bit", tx_bit, ref_readout(rd_sensor_exp, idx));
            end else begin
                other_errors++;
                $display("tx_valid high past the end of the %s readout", rd_sensor_exp.name());
            end
            bit_count <= bit_count + 1;
        end
    end

    task automatic finish_run();
        $display("mismatches %0d, other errors %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        other_errors++;
        timed_out = 1'b1;
        $display("timeout waiting for %s", what);
    endtask

    task automatic send_sample(sensor_id_t s, sample_t v);
        int        slot;
        int        cnt;
        mem_pins_t w;
        if (timed_out) begin
            return;
        end
        slot = int'(s);
        sample_sensor <= s;
        sample        <= v;
        sample_req    <= 1'b1;
        cnt = 0;
        while (!sample_ack && cnt < ack_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (!sample_ack) begin
            report_timeout("sample_ack to rise");
            return;
        end
        if (shadow_n[slot] < bank_depth) begin
            if (wr_log.size() != 1) begin
                other_errors++;
                $display("sample to %s made %0d writes instead of one", s.name(), wr_log.size());
            end else begin
                w = wr_log.pop_front();
                check_bank("mem_pins.bank", w.bank, exp_bank(s));
                check_addr("mem_pins.address", w.address, mem_addr_t'(shadow_n[slot]));
                check_word("mem_pins.wdata", w.wdata, {v.timestamp, v.adc});
            end
            shadow[slot][shadow_n[slot]] = {v.timestamp, v.adc};
            shadow_n[slot]++;
        end else if (wr_log.size() != 0) begin
            other_errors++;
            $display("sample to full bank of %s was written to the macro", s.name());
        end
        wr_log.delete();
        sample_req <= 1'b0;
        cnt = 0;
        while (sample_ack && cnt < ack_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (sample_ack) begin
            report_timeout("sample_ack to fall");
        end
    endtask

    task automatic send_random(sensor_id_t s);
        lcg_state = lcg_next(lcg_state);
        send_sample(s, sample_t'(lcg_state[23:8]));
    endtask

    task automatic do_readout(sensor_id_t s);
        int slot;
        int cnt;
        int got;
        if (timed_out) begin
            return;
        end
        slot = int'(s);
        rd_sensor_exp <= s;
        rd_base       <= bit_count;
        read_sensor   <= s;
        read_req      <= 1'b1;
        cnt = 0;
        while (!read_ack && cnt < read_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (!read_ack) begin
            report_timeout("read_ack to rise");
            return;
        end
        got = bit_count - rd_base;
        if (got != 16 * shadow_n[slot]) begin
            other_errors++;
            $display("readout of %s gave %0d bits, expected %0d", s.name(), got,
                     16 * shadow_n[slot]);
        end
        read_req <= 1'b0;
        cnt = 0;
        while (read_ack && cnt < ack_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (read_ack) begin
            report_timeout("read_ack to fall");
        end
        shadow_n[slot] = 0; // bank drained
    endtask

    initial begin
        sample_req    = 1'b0;
        sample_sensor = sensor_1;
        sample        = '0;
        read_req      = 1'b0;
        read_sensor   = sensor_1;
        rd_base       = 0;
        rd_sensor_exp = sensor_1;
        lcg_state     = 32'h15f2;
        timed_out     = 1'b0;
        foreach (shadow_n[i]) begin
            shadow_n[i] = 0;
        end
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_bit("mem_pins.pc_b", mem_pins.pc_b, 1'b1);
        check_bit("mem_pins.se", mem_pins.se, 1'b0);
        check_bit("mem_pins.we", mem_pins.we, 1'b0);
        check_bit("sample_ack", sample_ack, 1'b0);
        check_bit("read_ack", read_ack, 1'b0);
        check_bit("tx_valid", tx_valid, 1'b0);

        repeat (5) send_random(sensor_1);
        do_readout(sensor_1);
        do_readout(sensor_1); // now empty

        for (int i = 0; i < 10; i++) begin
            lcg_state = lcg_next(lcg_state);
            send_random(sensor_id_t'(lcg_state[16])); // sensor picked at random
        end
        do_readout(sensor_2);
        repeat (3) send_random(sensor_2);
        repeat (2) send_random(sensor_1);
        do_readout(sensor_1);
        do_readout(sensor_2);

        repeat (bank_depth + 3) send_random(sensor_2); // overflow the bank
        send_random(sensor_1);
        do_readout(sensor_2);
        do_readout(sensor_2);
        do_readout(sensor_1);
        finish_run();
    end

endmodule

/* compile.f */
+incdir+include
hdl/tag_mem_pkg.sv
hdl/sensor_pkg.sv
hdl/bank_fill_regs.sv
hdl/mem_access_seq.sv
hdl/sample_capture.sv
hdl/readout_ctrl.sv
hdl/word_serializer.sv
hdl/sensor_tag_mem.sv
verification/tb_sensor_tag_mem.sv
